// File: verilog/rate_ctrl_config.svh
`ifndef RATE_CTRL_CONFIG_SVH
`define RATE_CTRL_CONFIG_SVH

// datapath widths
`define RATE_W 16
`define INTEG_W 24
`define MOTOR_W 12

// largest motor command
`define MOTOR_MAX 4000

// hundredths of deg/s to 12.4 deg/s, 41/256 is close to 0.16
`define IMU_SCALE_MUL 8'sd41
`define IMU_SCALE_SHIFT 8

// fixed rate loop gains, signed 8 bit
`define RATE_KP 8'sd48
`define RATE_KI 8'sd6
`define RATE_KD 8'sd24

// output scaling of the summed terms
`define GAIN_SHIFT 4
`define I_SHIFT 6
`define MIX_SHIFT 2

`endif

// File: verilog/rate_ctrl_pkg.sv
`include "rate_ctrl_config.svh"

package rate_ctrl_pkg;

	// target and command rates, 12.4 deg/s
	typedef logic signed [`RATE_W-1:0] rate_t;

	// raw imu rates, hundredths of deg/s
	typedef logic signed [`RATE_W-1:0] imu_rate_t;

	// integrator accumulator
	typedef logic signed [`INTEG_W-1:0] integ_t;

	// unsigned motor command
	typedef logic [`MOTOR_W-1:0] motor_t;

	// pid sequencer, one multiply per p/i/d step
	typedef enum logic [2:0] {
		pid_idle,
		pid_error,
		pid_p,
		pid_i,
		pid_d,
		pid_sum
	} pid_state_e;

	// one-hot controller states
	typedef enum logic [3:0] {
		ctrl_waiting  = 4'b0001,
		ctrl_starting = 4'b0010,
		ctrl_active   = 4'b0100,
		ctrl_complete = 4'b1000
	} ctrl_state_e;

endpackage

// File: verilog/rate_pid.sv
`timescale 1ns/1ps
`include "rate_ctrl_config.svh"

module rate_pid
	import rate_ctrl_pkg::*;
#(
	parameter bit HAS_ANGLE_TERM = 1'b1
) (
	input  logic      start_signal,
	input  logic      resetn,
	input  logic      pid_start,
	input  rate_t     target_rate,
	input  imu_rate_t actual_rate,
	input  rate_t     angle_error,
	output rate_t     rate_out,
	output logic      pid_active,
	output logic      pid_done
);

	localparam int GAIN_W = 8;
	localparam int PROD_W = `INTEG_W + GAIN_W;
	localparam int ACC_W = PROD_W + 2;

	pid_state_e state;
	logic fin_q;

	// values kept across control cycles
	integ_t integ;
	rate_t prev_err;

	// per cycle datapath registers
	rate_t err_q;
	logic signed [PROD_W-1:0] prod_q;
	logic signed [ACC_W-1:0] acc;

	logic signed [`INTEG_W-1:0] mul_a;
	logic signed [GAIN_W-1:0] mul_b;
	logic signed [PROD_W-1:0] prod_c;
	logic signed [PROD_W-1:0] conv_rate;
	rate_t angle_term;
	logic signed [`RATE_W+1:0] err_wide;
	rate_t err_c;
	logic signed [`INTEG_W:0] integ_wide;
	logic signed [`RATE_W:0] err_diff;
	logic signed [ACC_W-1:0] acc_shifted;

	function automatic rate_t sat_rate(input logic signed [ACC_W-1:0] v);
		logic [ACC_W-`RATE_W:0] top;
		top = v[ACC_W-1:`RATE_W-1];
		if (top == '0 || top == '1)
			return v[`RATE_W-1:0];
		else if (v[ACC_W-1])
			return {1'b1, {(`RATE_W-1){1'b0}}};
		else
			return {1'b0, {(`RATE_W-1){1'b1}}};
	endfunction

	function automatic integ_t sat_integ(input logic signed [`INTEG_W:0] v);
		if (v[`INTEG_W] == v[`INTEG_W-1])
			return v[`INTEG_W-1:0];
		else if (v[`INTEG_W])
			return {1'b1, {(`INTEG_W-1){1'b0}}};
		else
			return {1'b0, {(`INTEG_W-1){1'b1}}};
	endfunction

	// imu product from the error step, scaled to 12.4
	assign conv_rate = prod_q >>> `IMU_SCALE_SHIFT;
	assign angle_term = HAS_ANGLE_TERM ? angle_error : '0;
	assign err_wide = target_rate + angle_term - $signed(conv_rate[`RATE_W+1:0]);
	assign err_c = sat_rate(err_wide);

	assign integ_wide = integ + err_c;
	assign err_diff = err_q - prev_err;
	assign acc_shifted = acc >>> `GAIN_SHIFT;

	// operand select for the shared multiplier
	always_comb begin
		mul_a = '0;
		mul_b = '0;
		case (state)
			pid_error: begin
				mul_a = actual_rate;
				mul_b = `IMU_SCALE_MUL;
			end
			pid_p: begin
				mul_a = err_c;
				mul_b = `RATE_KP;
			end
			pid_i: begin
				mul_a = integ >>> `I_SHIFT;
				mul_b = `RATE_KI;
			end
			pid_d: begin
				mul_a = err_diff;
				mul_b = `RATE_KD;
			end
			default: begin
				mul_a = '0;
				mul_b = '0;
			end
		endcase
	end

	assign prod_c = mul_a * mul_b;

	always_ff @(posedge start_signal or negedge resetn) begin
		if (!resetn) begin
			state <= pid_idle;
			fin_q <= 1'b0;
			pid_done <= 1'b0;
			rate_out <= '0;
			integ <= '0;
			prev_err <= '0;
		end else begin
			fin_q <= 1'b0;
			pid_done <= fin_q;
			// output stage, one edge after the last accumulate
			if (fin_q)
				rate_out <= sat_rate(acc_shifted);
			case (state)
				pid_idle: begin
					if (pid_start)
						state <= pid_error;
				end
				pid_error: state <= pid_p;
				pid_p: begin
					integ <= sat_integ(integ_wide);
					state <= pid_i;
				end
				pid_i: state <= pid_d;
				pid_d: begin
					prev_err <= err_q;
					state <= pid_sum;
				end
				pid_sum: begin
					fin_q <= 1'b1;
					state <= pid_idle;
				end
				default: state <= pid_idle;
			endcase
		end
	end

	// product of one step is accumulated in the next
	always_ff @(posedge start_signal) begin
		case (state)
			pid_error: prod_q <= prod_c;
			pid_p: begin
				err_q <= err_c;
				prod_q <= prod_c;
			end
			pid_i: begin
				acc <= prod_q;
				prod_q <= prod_c;
			end
			pid_d: begin
				acc <= acc + prod_q;
				prod_q <= prod_c;
			end
			pid_sum: acc <= acc + prod_q;
			default: begin
			end
		endcase
	end

	assign pid_active = (state != pid_idle) || fin_q;

endmodule

// File: verilog/body_frame_controller.sv
`timescale 1ns/1ps

module body_frame_controller
	import rate_ctrl_pkg::*;
(
	input  logic      start_signal,
	input  logic      resetn,
	input  logic      cycle_start,
	input  rate_t     yaw_target,
	input  rate_t     roll_target,
	input  rate_t     pitch_target,
	input  imu_rate_t yaw_rotation,
	input  imu_rate_t roll_rotation,
	input  imu_rate_t pitch_rotation,
	input  rate_t     roll_angle_error,
	input  rate_t     pitch_angle_error,
	output rate_t     yaw_rate_out,
	output rate_t     roll_rate_out,
	output rate_t     pitch_rate_out,
	output logic      complete_signal,
	output logic      busy
);

	ctrl_state_e state;
	ctrl_state_e next_state;
	logic accept;
	logic pid_start;

	logic yaw_active;
	logic roll_active;
	logic pitch_active;
	logic yaw_done;
	logic roll_done;
	logic pitch_done;
	logic all_active;
	logic all_done;

	// inputs held for the whole cycle
	rate_t     cap_yaw_target;
	rate_t     cap_roll_target;
	rate_t     cap_pitch_target;
	imu_rate_t cap_yaw_rotation;
	imu_rate_t cap_roll_rotation;
	imu_rate_t cap_pitch_rotation;
	rate_t     cap_roll_angle_error;
	rate_t     cap_pitch_angle_error;

	// requests outside the waiting state are dropped
	assign accept = (state == ctrl_waiting) && cycle_start;

	always_ff @(posedge start_signal) begin
		if (accept) begin
			cap_yaw_target <= yaw_target;
			cap_roll_target <= roll_target;
			cap_pitch_target <= pitch_target;
			cap_yaw_rotation <= yaw_rotation;
			cap_roll_rotation <= roll_rotation;
			cap_pitch_rotation <= pitch_rotation;
			cap_roll_angle_error <= roll_angle_error;
			cap_pitch_angle_error <= pitch_angle_error;
		end
	end

	always_ff @(posedge start_signal or negedge resetn) begin
		if (!resetn) begin
			state <= ctrl_waiting;
			pid_start <= 1'b0;
		end else begin
			state <= next_state;
			pid_start <= accept;
		end
	end

	assign all_active = yaw_active && roll_active && pitch_active;
	assign all_done = yaw_done && roll_done && pitch_done;

	always_comb begin
		next_state = state;
		case (state)
			ctrl_waiting: begin
				if (cycle_start)
					next_state = ctrl_starting;
			end
			ctrl_starting: begin
				if (all_active)
					next_state = ctrl_active;
			end
			ctrl_active: begin
				if (all_done)
					next_state = ctrl_complete;
			end
			ctrl_complete: next_state = ctrl_waiting;
			default: next_state = ctrl_waiting;
		endcase
	end

	assign complete_signal = (state == ctrl_complete);
	assign busy = (state != ctrl_waiting);

	// yaw has no angle loop above it
	rate_pid #(.HAS_ANGLE_TERM(1'b0)) yaw_pid (
		.start_signal(start_signal),
		.resetn(resetn),
		.pid_start(pid_start),
		.target_rate(cap_yaw_target),
		.actual_rate(cap_yaw_rotation),
		.angle_error('0),
		.rate_out(yaw_rate_out),
		.pid_active(yaw_active),
		.pid_done(yaw_done)
	);

	rate_pid #(.HAS_ANGLE_TERM(1'b1)) roll_pid (
		.start_signal(start_signal),
		.resetn(resetn),
		.pid_start(pid_start),
		.target_rate(cap_roll_target),
		.actual_rate(cap_roll_rotation),
		.angle_error(cap_roll_angle_error),
		.rate_out(roll_rate_out),
		.pid_active(roll_active),
		.pid_done(roll_done)
	);

	rate_pid #(.HAS_ANGLE_TERM(1'b1)) pitch_pid (
		.start_signal(start_signal),
		.resetn(resetn),
		.pid_start(pid_start),
		.target_rate(cap_pitch_target),
		.actual_rate(cap_pitch_rotation),
		.angle_error(cap_pitch_angle_error),
		.rate_out(pitch_rate_out),
		.pid_active(pitch_active),
		.pid_done(pitch_done)
	);

endmodule

// File: verilog/motor_mixer.sv
`timescale 1ns/1ps
`include "rate_ctrl_config.svh"

module motor_mixer
	import rate_ctrl_pkg::*;
(
	input  logic   start_signal,
	input  logic   resetn,
	input  logic   complete_signal,
	input  motor_t throttle,
	input  rate_t  yaw_rate,
	input  rate_t  roll_rate,
	input  rate_t  pitch_rate,
	output motor_t motor_0,
	output motor_t motor_1,
	output motor_t motor_2,
	output motor_t motor_3,
	output logic   motor_valid
);

	// throttle plus three quarter-scale rates fits here
	localparam int MIX_W = `RATE_W + 2;

	logic signed [MIX_W-1:0] thr_s;
	logic signed [MIX_W-1:0] yaw_s;
	logic signed [MIX_W-1:0] roll_s;
	logic signed [MIX_W-1:0] pitch_s;
	logic signed [MIX_W-1:0] mix_0;
	logic signed [MIX_W-1:0] mix_1;
	logic signed [MIX_W-1:0] mix_2;
	logic signed [MIX_W-1:0] mix_3;

	function automatic motor_t clamp_motor(input logic signed [MIX_W-1:0] v);
		if (v < 0)
			return '0;
		else if (v > `MOTOR_MAX)
			return motor_t'(`MOTOR_MAX);
		else
			return v[`MOTOR_W-1:0];
	endfunction

	assign thr_s = $signed({{(MIX_W-`MOTOR_W){1'b0}}, throttle});
	assign yaw_s = yaw_rate >>> `MIX_SHIFT;
	assign roll_s = roll_rate >>> `MIX_SHIFT;
	assign pitch_s = pitch_rate >>> `MIX_SHIFT;

	// quad-X, diagonal pairs share the yaw sign
	assign mix_0 = thr_s + pitch_s + roll_s - yaw_s;
	assign mix_1 = thr_s + pitch_s - roll_s + yaw_s;
	assign mix_2 = thr_s - pitch_s - roll_s - yaw_s;
	assign mix_3 = thr_s - pitch_s + roll_s + yaw_s;

	always_ff @(posedge start_signal or negedge resetn) begin
		if (!resetn) begin
			motor_0 <= '0;
			motor_1 <= '0;
			motor_2 <= '0;
			motor_3 <= '0;
			motor_valid <= 1'b0;
		end else begin
			motor_valid <= complete_signal;
			// values hold between cycles
			if (complete_signal) begin
				motor_0 <= clamp_motor(mix_0);
				motor_1 <= clamp_motor(mix_1);
				motor_2 <= clamp_motor(mix_2);
				motor_3 <= clamp_motor(mix_3);
			end
		end
	end

endmodule

// File: verilog/flight_rate_top.sv
`timescale 1ns/1ps

module flight_rate_top
	import rate_ctrl_pkg::*;
(
	input  logic      start_signal,
	input  logic      resetn,
	input  logic      cycle_start,
	input  rate_t     yaw_target,
	input  rate_t     roll_target,
	input  rate_t     pitch_target,
	input  imu_rate_t yaw_rotation,
	input  imu_rate_t roll_rotation,
	input  imu_rate_t pitch_rotation,
	input  rate_t     roll_angle_error,
	input  rate_t     pitch_angle_error,
	input  motor_t    throttle,
	output logic      busy,
	output motor_t    motor_0,
	output motor_t    motor_1,
	output motor_t    motor_2,
	output motor_t    motor_3,
	output logic      motor_valid
);

	// rate commands, held until the next cycle
	rate_t yaw_rate;
	rate_t roll_rate;
	rate_t pitch_rate;
	logic complete_signal;

	body_frame_controller i_ctrl (
		.start_signal(start_signal),
		.resetn(resetn),
		.cycle_start(cycle_start),
		.yaw_target(yaw_target),
		.roll_target(roll_target),
		.pitch_target(pitch_target),
		.yaw_rotation(yaw_rotation),
		.roll_rotation(roll_rotation),
		.pitch_rotation(pitch_rotation),
		.roll_angle_error(roll_angle_error),
		.pitch_angle_error(pitch_angle_error),
		.yaw_rate_out(yaw_rate),
		.roll_rate_out(roll_rate),
		.pitch_rate_out(pitch_rate),
		.complete_signal(complete_signal),
		.busy(busy)
	);

	motor_mixer i_mixer (
		.start_signal(start_signal),
		.resetn(resetn),
		.complete_signal(complete_signal),
		.throttle(throttle),
		.yaw_rate(yaw_rate),
		.roll_rate(roll_rate),
		.pitch_rate(pitch_rate),
		.motor_0(motor_0),
		.motor_1(motor_1),
		.motor_2(motor_2),
		.motor_3(motor_3),
		.motor_valid(motor_valid)
	);

endmodule

// File: sim/flight_rate_props.sv
`timescale 1ns/1ps

module flight_rate_props (
	input logic start_signal,
	input logic resetn,
	input logic complete_signal,
	input logic motor_valid,
	input logic busy
);

	// complete is a single cycle pulse
	complete_pulse: assert property (@(posedge start_signal) disable iff (!resetn)
		complete_signal |=> !complete_signal)
		else $error("complete_signal high for more than one cycle");

	valid_after_complete: assert property (@(posedge start_signal) disable iff (!resetn)
		complete_signal |=> motor_valid)
		else $error("motor_valid did not follow complete_signal");

	valid_needs_complete: assert property (@(posedge start_signal) disable iff (!resetn)
		motor_valid |-> $past(complete_signal))
		else $error("motor_valid without complete_signal one cycle before");

	// busy drops only once the cycle has completed
	busy_until_complete: assert property (@(posedge start_signal) disable iff (!resetn)
		$fell(busy) |-> $past(complete_signal))
		else $error("busy fell before complete_signal");

endmodule

bind flight_rate_top flight_rate_props i_props (
	.start_signal(start_signal),
	.resetn(resetn),
	.complete_signal(complete_signal),
	.motor_valid(motor_valid),
	.busy(busy)
);

// File: sim/tb_flight_rate.sv
`timescale 1ns/1ps
`include "rate_ctrl_config.svh"

module tb_flight_rate
	import rate_ctrl_pkg::*;
();

	localparam int N_RANDOM = 200;
	localparam int N_EXTREME = 24;
	localparam int N_IGNORED = 8;
	localparam int N_RESET = 4;
	localparam int N_PLANNED = 1 + N_RANDOM + N_EXTREME + N_IGNORED + N_RESET + 2;
	localparam longint WATCHDOG_NS = (N_PLANNED * 12 + 200) * 40;

	logic start_signal;
	logic resetn;
	logic cycle_start;
	rate_t yaw_target;
	rate_t roll_target;
	rate_t pitch_target;
	imu_rate_t yaw_rotation;
	imu_rate_t roll_rotation;
	imu_rate_t pitch_rotation;
	rate_t roll_angle_error;
	rate_t pitch_angle_error;
	motor_t throttle;
	logic busy;
	motor_t motor_0;
	motor_t motor_1;
	motor_t motor_2;
	motor_t motor_3;
	logic motor_valid;

	logic [31:0] lcg_state;
	int fail_count;
	int clamp_hits;
	int sat_hits;
	// reference state per axis (0 yaw, 1 roll, 2 pitch)
	int integ_m[3];
	int prev_m[3];

	flight_rate_top i_dut (
		.start_signal(start_signal),
		.resetn(resetn),
		.cycle_start(cycle_start),
		.yaw_target(yaw_target),
		.roll_target(roll_target),
		.pitch_target(pitch_target),
		.yaw_rotation(yaw_rotation),
		.roll_rotation(roll_rotation),
		.pitch_rotation(pitch_rotation),
		.roll_angle_error(roll_angle_error),
		.pitch_angle_error(pitch_angle_error),
		.throttle(throttle),
		.busy(busy),
		.motor_0(motor_0),
		.motor_1(motor_1),
		.motor_2(motor_2),
		.motor_3(motor_3),
		.motor_valid(motor_valid)
	);

	always #20 start_signal = ~start_signal;

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// uniform value in [-span, span)
	function automatic int rand_span(input int span);
		logic [31:0] r;
		int u;
		r = next_rand();
		u = int'(r[30:8]);
		return (u % (2 * span)) - span;
	endfunction

	function automatic int pick_extreme();
		logic [31:0] r;
		r = next_rand();
		case (r[25:24])
			2'd0: return -32768;
			2'd1: return 32767;
			2'd2: return -20000;
			default: return 20000;
		endcase
	endfunction

	function automatic int sat(input int v, input int lo, input int hi);
		if (v < lo)
			return lo;
		else if (v > hi)
			return hi;
		else
			return v;
	endfunction

	// one axis of the rate PID that updates integrator and previous error
	function automatic int pid_model(input int axis, input int target, input int actual,
			input int angle);
		int conv;
		int err;
		int p_term;
		int i_term;
		int d_term;
		int sum;
		int out;
		conv = (actual * `IMU_SCALE_MUL) >>> `IMU_SCALE_SHIFT;
		err = sat(target + angle - conv, -(1 << (`RATE_W - 1)), (1 << (`RATE_W - 1)) - 1);
		integ_m[axis] = sat(integ_m[axis] + err, -(1 << (`INTEG_W - 1)),
			(1 << (`INTEG_W - 1)) - 1);
		p_term = `RATE_KP * err;
		i_term = `RATE_KI * (integ_m[axis] >>> `I_SHIFT);
		d_term = `RATE_KD * (err - prev_m[axis]);
		prev_m[axis] = err;
		sum = (p_term + i_term + d_term) >>> `GAIN_SHIFT;
		out = sat(sum, -(1 << (`RATE_W - 1)), (1 << (`RATE_W - 1)) - 1);
		if (out != sum)
			sat_hits++;
		return out;
	endfunction

	function automatic int mix_clamp(input int v);
		if (v < 0) begin
			clamp_hits++;
			return 0;
		end else if (v > `MOTOR_MAX) begin
			clamp_hits++;
			return `MOTOR_MAX;
		end
		return v;
	endfunction

	task automatic fail_run(input string why);
		fail_count++;
		$display("%s", why);
		$display("FAIL: see errors above");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_motor(input string what, input motor_t got, input motor_t exp);
		if (got !== exp)
			fail_run($sformatf("mismatch at %0t: %s got %0d expected %0d",
				$time, what, got, exp));
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp)
			fail_run($sformatf("mismatch at %0t: %s got %b expected %b",
				$time, what, got, exp));
	endtask

	task automatic wait_idle();
		int waited;
		waited = 0;
		@(negedge start_signal);
		while (busy) begin
			@(negedge start_signal);
			waited++;
			if (waited > 20)
				fail_run("busy stayed high, controller never returned to waiting");
		end
	endtask

	task automatic clear_model();
		for (int a = 0; a < 3; a++) begin
			integ_m[a] = 0;
			prev_m[a] = 0;
		end
	endtask

	task automatic apply_reset(input int cycles);
		@(posedge start_signal);
		resetn <= 1'b0;
		cycle_start <= 1'b0;
		repeat (cycles) @(posedge start_signal);
		resetn <= 1'b1;
		clear_model();
	endtask

	// one accepted request with optional extra requests while busy
	task automatic run_cycle(input int yt, input int rt, input int pt, input int yr,
			input int rr, input int pr, input int rae, input int pae, input int thr,
			input bit extra);
		int lat;
		int y_cmd;
		int r_cmd;
		int p_cmd;
		int ys;
		int rs;
		int ps;
		motor_t exp_m[4];
		wait_idle();
		@(posedge start_signal);
		cycle_start <= 1'b1;
		yaw_target <= rate_t'(yt);
		roll_target <= rate_t'(rt);
		pitch_target <= rate_t'(pt);
		yaw_rotation <= imu_rate_t'(yr);
		roll_rotation <= imu_rate_t'(rr);
		pitch_rotation <= imu_rate_t'(pr);
		roll_angle_error <= rate_t'(rae);
		pitch_angle_error <= rate_t'(pae);
		throttle <= motor_t'(thr);
		// request sampled here
		@(posedge start_signal);
		cycle_start <= 1'b0;
		y_cmd = pid_model(0, yt, yr, 0);
		r_cmd = pid_model(1, rt, rr, rae);
		p_cmd = pid_model(2, pt, pr, pae);
		ys = y_cmd >>> `MIX_SHIFT;
		rs = r_cmd >>> `MIX_SHIFT;
		ps = p_cmd >>> `MIX_SHIFT;
		exp_m[0] = motor_t'(mix_clamp(thr + ps + rs - ys));
		exp_m[1] = motor_t'(mix_clamp(thr + ps - rs + ys));
		exp_m[2] = motor_t'(mix_clamp(thr - ps - rs - ys));
		exp_m[3] = motor_t'(mix_clamp(thr - ps + rs + ys));
		for (lat = 1; lat <= 9; lat++) begin
			@(posedge start_signal);
			if (extra && (lat % 2 == 1) && (lat < 8)) begin
				cycle_start <= 1'b1;
				yaw_target <= rate_t'(rand_span(30000));
				roll_target <= rate_t'(rand_span(30000));
				pitch_rotation <= imu_rate_t'(rand_span(30000));
			end else begin
				cycle_start <= 1'b0;
			end
			@(negedge start_signal);
			check_flag("busy", busy, lat < 9);
			check_flag("motor_valid", motor_valid, lat == 9);
		end
		check_motor("motor_0", motor_0, exp_m[0]);
		check_motor("motor_1", motor_1, exp_m[1]);
		check_motor("motor_2", motor_2, exp_m[2]);
		check_motor("motor_3", motor_3, exp_m[3]);
		if (extra) begin
			// nothing queued from the dropped requests
			repeat (6) begin
				@(negedge start_signal);
				check_flag("motor_valid after dropped request", motor_valid, 1'b0);
				check_flag("busy after dropped request", busy, 1'b0);
			end
		end
	endtask

	task automatic run_random_cycle(input bit extra);
		run_cycle(rand_span(2048), rand_span(2048), rand_span(2048), rand_span(12800),
			rand_span(12800), rand_span(12800), rand_span(512), rand_span(512),
			1000 + rand_span(1000) + 1000, extra);
	endtask

	task automatic run_extreme_cycle();
		logic [31:0] r;
		int thr;
		r = next_rand();
		case (r[21:20])
			2'd0: thr = 0;
			2'd1: thr = 4095;
			2'd2: thr = 150;
			default: thr = 3950;
		endcase
		run_cycle(pick_extreme(), pick_extreme(), pick_extreme(), pick_extreme(),
			pick_extreme(), pick_extreme(), pick_extreme(), pick_extreme(), thr, 1'b0);
	endtask

	initial begin
		#(WATCHDOG_NS);
		fail_run("timeout: tests did not finish before the watchdog limit");
	end

	initial begin
		start_signal = 1'b0;
		resetn = 1'b0;
		cycle_start = 1'b0;
		yaw_target = '0;
		roll_target = '0;
		pitch_target = '0;
		yaw_rotation = '0;
		roll_rotation = '0;
		pitch_rotation = '0;
		roll_angle_error = '0;
		pitch_angle_error = '0;
		throttle = '0;
		lcg_state = 32'd92945;
		fail_count = 0;
		clamp_hits = 0;
		sat_hits = 0;
		clear_model();
		repeat (10) @(posedge start_signal);
		resetn <= 1'b1;

		@(negedge start_signal);
		check_flag("motor_valid after reset", motor_valid, 1'b0);
		check_flag("busy after reset", busy, 1'b0);
		check_motor("motor_0 after reset", motor_0, '0);
		check_motor("motor_1 after reset", motor_1, '0);
		check_motor("motor_2 after reset", motor_2, '0);
		check_motor("motor_3 after reset", motor_3, '0);

		run_random_cycle(1'b0);
		repeat (N_RANDOM) run_random_cycle(1'b0);

		clamp_hits = 0;
		sat_hits = 0;
		repeat (N_EXTREME) run_extreme_cycle();
		if (clamp_hits == 0)
			fail_run("extreme cycles never drove a motor command into its clamp");
		if (sat_hits == 0)
			fail_run("extreme cycles never saturated a rate PID output");

		repeat (N_IGNORED) run_random_cycle(1'b1);

		// reset in the middle of a cycle
		wait_idle();
		@(posedge start_signal);
		cycle_start <= 1'b1;
		yaw_target <= rate_t'(rand_span(2048));
		roll_target <= rate_t'(rand_span(2048));
		@(posedge start_signal);
		cycle_start <= 1'b0;
		repeat (4) @(posedge start_signal);
		apply_reset(3);
		@(negedge start_signal);
		check_flag("busy after mid-run reset", busy, 1'b0);
		check_flag("motor_valid after mid-run reset", motor_valid, 1'b0);
		check_motor("motor_0 after mid-run reset", motor_0, '0);
		check_motor("motor_1 after mid-run reset", motor_1, '0);
		check_motor("motor_2 after mid-run reset", motor_2, '0);
		check_motor("motor_3 after mid-run reset", motor_3, '0);
		repeat (N_RESET) run_random_cycle(1'b0);

		if (fail_count == 0) begin
			$display("PASS: all tests");
			$finish;
		end else begin
			fail_run("errors were recorded during the run");
		end
	end

endmodule

// File: list.f
+incdir+verilog
verilog/rate_ctrl_pkg.sv
verilog/rate_pid.sv
verilog/body_frame_controller.sv
verilog/motor_mixer.sv
verilog/flight_rate_top.sv
sim/flight_rate_props.sv
sim/tb_flight_rate.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f list.f \
		--top-module tb_flight_rate -Mdir obj_dir -o sim_flight_rate

run: compile
	./obj_dir/sim_flight_rate

clean:
	rm -rf obj_dir
